// ==== gb_video_top.f ====
rtl/gb_lcd_pkg.sv
rtl/dvi_pkg.sv
rtl/lcd_capture.sv
rtl/frame_buffer.sv
rtl/dvi_scanout.sv
rtl/key_debounce.sv
rtl/gb_video_top.sv
tests/tb_gb_video_top.sv

// ==== Bender.yml ====
package:
  name: gb_video_top

sources:
  # Packages first, top level last
  - rtl/gb_lcd_pkg.sv
  - rtl/dvi_pkg.sv
  - rtl/lcd_capture.sv
  - rtl/frame_buffer.sv
  - rtl/dvi_scanout.sv
  - rtl/key_debounce.sv
  - rtl/gb_video_top.sv
  - target: test
    files:
      - tests/tb_gb_video_top.sv

// ==== tests/tb_gb_video_top.sv ====
`timescale 1ns/1ps

module tb_gb_video_top import gb_lcd_pkg::*, dvi_pkg::*; ();

  localparam int SCALE     = 2;
  localparam int DEBOUNCE  = 16;
  localparam int SEED      = 99560;
  localparam int FRAME_CYC = H_TOTAL * V_TOTAL;
  // Worst line is 164 pixels of up to 6 cycles each plus hs
  localparam int LINE_MAX  = (LCD_W + 4) * 6 + 2;
  localparam int LIMIT     = 6 * FRAME_CYC + 2 * LCD_H * LINE_MAX + 1000;

  logic       clk = 1'b0;
  logic       rst;
  lcd_bus_t   lcd;
  logic       button;
  dvi_video_t video;

  shade_t     ref_img [FB_DEPTH];  // What the buffer should hold
  logic       check_en;            // Compare pixels of this frame
  logic       exp_sel;             // Expected palette, 1 gray

  always #5 clk = ~clk;  // 10 ns

  gb_video_top #(
    .SCALE           (SCALE),
    .DEBOUNCE_CYCLES (DEBOUNCE)
  ) i_dut (
    .clk    (clk),
    .rst    (rst),
    .lcd    (lcd),
    .button (button),
    .video  (video)
  );

  //////////////////////////////////////////////////
  // Checking helpers

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail at time %0t: %s got 0x%0h, expected 0x%0h", $time, name, got, exp);
      $display(">>> FAIL");
      $fatal(1, "Value mismatch on %s", name);
    end
  endtask

  task automatic check_quiet();
    check_value("video.de", video.de, 1'b0);
    check_value("video.hs", video.hs, 1'b0);
    check_value("video.vs", video.vs, 1'b0);
    check_value("video.rgb", video.rgb, '0);
  endtask

  // Expected colour at active position (x, y)
  function automatic rgb_t expected_rgb(input int x, input int y, input logic sel);
    int     xo;
    int     yo;
    shade_t s;
    xo = (H_ACTIVE - LCD_W * SCALE) / 2;
    yo = (V_ACTIVE - LCD_H * SCALE) / 2;
    if (x < xo || x >= xo + LCD_W * SCALE || y < yo || y >= yo + LCD_H * SCALE) begin
      return BORDER_RGB;
    end
    s = ref_img[((y - yo) / SCALE) * LCD_W + (x - xo) / SCALE];  // 2x2 blocks
    return sel ? PALETTE_GRAY[s] : PALETTE_GREEN[s];
  endfunction

  //////////////////////////////////////////////////
  // Stimulus helpers

  // One-cycle strobe, then one idle cycle
  task automatic strobe(input logic hs, input logic vs, input logic cpl,
                        input logic valid, input shade_t pixel);
    lcd_bus_t b;
    b = '{hs: hs, vs: vs, cpl: cpl, valid: valid, pixel: pixel};
    @(posedge clk);
    lcd <= b;
    @(posedge clk);
    lcd <= '0;
  endtask

  task automatic send_frame(input bit ragged);
    int     npix;
    shade_t s;
    strobe(1'b0, 1'b1, 1'b0, 1'b0, 2'd0);  // Frame start
    for (int y = 0; y < LCD_H; y++) begin
      npix = LCD_W;
      if (ragged) begin
        case ($urandom_range(3))
          0: npix = LCD_W - 1 - $urandom_range(19);  // Short line keeps old pixels
          1: npix = LCD_W + 1 + $urandom_range(3);   // Overrun is dropped
          default: npix = LCD_W;
        endcase
      end
      for (int i = 0; i < npix; i++) begin
        if ($urandom_range(7) == 0) begin
          strobe(1'b0, 1'b0, 1'b1, 1'b0, shade_t'($urandom_range(3)));  // Ignored
        end
        repeat ($urandom_range(2)) @(posedge clk);
        s = shade_t'($urandom_range(3));
        strobe(1'b0, 1'b0, 1'b1, 1'b1, s);
        if (i < LCD_W) begin
          ref_img[y * LCD_W + i] = s;
        end
      end
      strobe(1'b1, 1'b0, 1'b0, 1'b0, 2'd0);  // Line end
    end
  endtask

  task automatic hold_button(input int press_cyc, input int release_cyc);
    @(posedge clk);
    button <= 1'b1;
    repeat (press_cyc) @(posedge clk);
    button <= 1'b0;
    repeat (release_cyc) @(posedge clk);
  endtask

  task automatic wait_frame();
    @(negedge video.vs);
  endtask

  // Skip to a frame start, then compare one whole frame
  task automatic check_frame(input logic sel);
    wait_frame();
    exp_sel  = sel;
    check_en = 1'b1;
    wait_frame();
    check_en = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // Output monitor

  dvi_video_t prev_v;
  int         col;
  int         row;
  int         hs_len;
  int         vs_lines;

  always @(posedge clk) begin
    if (rst) begin
      prev_v   = '0;
      col      = 0;
      row      = 0;
      hs_len   = 0;
      vs_lines = 0;
    end else begin
      if (video.de) begin
        if (check_en) begin
          check_value("video.rgb", video.rgb, expected_rgb(col, row, exp_sel));
        end
        col++;
      end
      if (prev_v.de && !video.de) begin
        check_value("de cycles per line", col, H_ACTIVE);
        col = 0;
        row++;
      end
      if (video.hs) begin
        hs_len++;
      end
      if (prev_v.hs && !video.hs) begin
        check_value("hs width", hs_len, H_SYNC);
        hs_len = 0;
        if (video.vs) begin
          vs_lines++;  // Lines inside vs
        end
      end
      if (!prev_v.vs && video.vs) begin
        check_value("de lines per frame", row, V_ACTIVE);
      end
      if (prev_v.vs && !video.vs) begin
        check_value("vs lines", vs_lines, V_SYNC);
        vs_lines = 0;
        row      = 0;  // Rows count from vs fall
      end
      prev_v = video;
    end
  end

  //////////////////////////////////////////////////
  // Main sequence and watchdog

  initial begin
    lcd      = '0;
    button   = 1'b0;
    rst      = 1'b1;
    check_en = 1'b0;
    exp_sel  = 1'b0;
    void'($urandom(SEED));
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      if (i == 9) begin
        rst <= 1'b0;
      end
      @(negedge clk);
      check_quiet();
    end
    @(negedge clk);
    check_quiet();        // First cycle out of reset
    send_frame(1'b0);     // Full image
    hold_button(5, 40);   // Glitch too short to toggle
    check_frame(1'b0);
    hold_button(40, 40);  // Clean press
    check_frame(1'b1);
    send_frame(1'b1);     // Ragged update
    check_frame(1'b1);
    $display(">>> PASS");
    $finish;
  end

  initial begin
    repeat (LIMIT) @(posedge clk);
    $display("Timeout: the video test did not finish within %0d cycles", LIMIT);
    $display(">>> FAIL");
    $fatal(1, "Watchdog expired");
  end

endmodule

// ==== rtl/gb_video_top.sv ====
`timescale 1ns/1ps

module gb_video_top import gb_lcd_pkg::*, dvi_pkg::*; #(
  parameter int SCALE           = 2,   // Pixel replication
  parameter int DEBOUNCE_CYCLES = 16   // Button settle time
) (
  input  logic       clk,
  input  logic       rst,
  input  lcd_bus_t   lcd,     // Core LCD output
  input  logic       button,  // Palette button
  output dvi_video_t video    // To DVI transmitter
);

  fb_write_t wr;
  fb_addr_t  rd_addr;
  shade_t    rd_data;
  logic      palette_sel;

  lcd_capture lcd_capture (
    .clk (clk),
    .rst (rst),
    .lcd (lcd),
    .wr  (wr)           // Write port
  );

  frame_buffer frame_buffer (
    .clk     (clk),
    .wr      (wr),
    .rd_addr (rd_addr),
    .rd_data (rd_data)  // One cycle later
  );

  dvi_scanout #(
    .SCALE (SCALE)
  ) dvi_scanout (
    .clk         (clk),
    .rst         (rst),
    .palette_sel (palette_sel),
    .rd_data     (rd_data),
    .rd_addr     (rd_addr),
    .video       (video)
  );

  key_debounce #(
    .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
  ) key_debounce (
    .clk         (clk),
    .rst         (rst),
    .button      (button),
    .palette_sel (palette_sel)
  );

endmodule

// ==== rtl/key_debounce.sv ====
`timescale 1ns/1ps

module key_debounce #(
  parameter int DEBOUNCE_CYCLES = 16  // Stable cycles per edge
) (
  input  logic clk,
  input  logic rst,
  input  logic button,       // Raw push button
  output logic palette_sel   // Toggles per clean press
);

  localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

  typedef logic [CNT_W-1:0] cnt_t;
  localparam cnt_t CNT_LAST = cnt_t'(DEBOUNCE_CYCLES - 1);

  typedef enum logic {IDLE, PRESSED} state_t;

  logic   btn_s1;
  logic   btn_s2;
  logic   level;  // Input matches the edge the FSM waits for
  state_t state;
  cnt_t   cnt;

  // Two-flop synchroniser
  always_ff @(posedge clk) begin
    if (rst) begin
      btn_s1 <= 1'b0;
      btn_s2 <= 1'b0;
    end else begin
      btn_s1 <= button;
      btn_s2 <= btn_s1;
    end
  end

  assign level = (state == IDLE) ? btn_s2 : ~btn_s2;

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= IDLE;
      cnt         <= '0;
      palette_sel <= 1'b0;  // Green after reset
    end else if (!level) begin
      cnt <= '0;            // Bounce restarts the count
    end else if (cnt == CNT_LAST) begin
      cnt <= '0;
      case (state)
        IDLE: begin
          state       <= PRESSED;
          palette_sel <= ~palette_sel;
        end
        default: state <= IDLE;  // Release held long enough
      endcase
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

// ==== rtl/dvi_scanout.sv ====
`timescale 1ns/1ps

module dvi_scanout import gb_lcd_pkg::*, dvi_pkg::*; #(
  parameter int SCALE = 2  // Pixel replication, 1 or 2
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       palette_sel,  // 0 green, 1 gray
  input  shade_t     rd_data,
  output fb_addr_t   rd_addr,
  output dvi_video_t video
);

  // Image window inside the active area
  localparam int X_OFF = (H_ACTIVE - LCD_W * SCALE) / 2;  // 20 at SCALE 2
  localparam int X_END = X_OFF + LCD_W * SCALE;
  localparam int Y_OFF = (V_ACTIVE - LCD_H * SCALE) / 2;  // 6 at SCALE 2
  localparam int Y_END = Y_OFF + LCD_H * SCALE;
  localparam int SUB_W = (SCALE > 1) ? $clog2(SCALE) : 1;

  typedef logic [SUB_W-1:0] sub_t;
  localparam sub_t SUB_LAST = sub_t'(SCALE - 1);

  // Per-pixel timing flags, carried down the pipe
  typedef struct packed {
    logic hs;
    logic vs;
    logic de;
    logic win;  // Inside the image window
  } flags_t;

  hcount_t  hcnt;
  vcount_t  vcnt;
  logic     line_end;
  logic     win_h;
  logic     win_v;
  flags_t   f0;         // Counter stage
  flags_t   f1;         // Address stage
  flags_t   f2;         // Memory stage
  lcd_x_t   src_x;      // Buffer column
  sub_t     sub_x;      // Repeat count within a column
  sub_t     sub_y;      // Repeat count within a row
  fb_addr_t line_base;  // Buffer row * 160
  rgb_t     pix_rgb;

  //////////////////////////////////////////////////
  // Raster counters

  assign line_end = (hcnt == hcount_t'(H_TOTAL - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      hcnt <= '0;
      vcnt <= '0;
    end else if (line_end) begin
      hcnt <= '0;
      vcnt <= (vcnt == vcount_t'(V_TOTAL - 1)) ? '0 : vcnt + 1'b1;
    end else begin
      hcnt <= hcnt + 1'b1;
    end
  end

  assign win_h = (hcnt >= hcount_t'(X_OFF)) && (hcnt < hcount_t'(X_END));
  assign win_v = (vcnt >= vcount_t'(Y_OFF)) && (vcnt < vcount_t'(Y_END));

  always_comb begin
    f0.hs  = (hcnt >= hcount_t'(H_ACTIVE + H_FRONT)) &&
             (hcnt < hcount_t'(H_ACTIVE + H_FRONT + H_SYNC));
    f0.vs  = (vcnt >= vcount_t'(V_ACTIVE + V_FRONT)) &&
             (vcnt < vcount_t'(V_ACTIVE + V_FRONT + V_SYNC));
    f0.de  = (hcnt < hcount_t'(H_ACTIVE)) && (vcnt < vcount_t'(V_ACTIVE));
    f0.win = win_h && win_v;  // Window lies inside active area
  end

  //////////////////////////////////////////////////
  // Source position stepped instead of divided

  always_ff @(posedge clk) begin
    if (rst || !win_h) begin
      src_x <= '0;  // Parked at column 0 until the window opens
      sub_x <= '0;
    end else if (sub_x == SUB_LAST) begin
      sub_x <= '0;
      src_x <= src_x + 1'b1;
    end else begin
      sub_x <= sub_x + 1'b1;
    end
  end

  // Row steps once per SCALE lines at line end
  always_ff @(posedge clk) begin
    if (rst) begin
      line_base <= '0;
      sub_y     <= '0;
    end else if (line_end) begin
      if (!win_v) begin
        line_base <= '0;
        sub_y     <= '0;
      end else if (sub_y == SUB_LAST) begin
        sub_y     <= '0;
        line_base <= line_base + fb_addr_t'(LCD_W);
      end else begin
        sub_y <= sub_y + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Pipeline of address, memory read and output

  always_ff @(posedge clk) begin
    rd_addr <= f0.win ? line_base + fb_addr_t'(src_x) : '0;  // Stage 1
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      f1 <= '0;
      f2 <= '0;
    end else begin
      f1 <= f0;
      f2 <= f1;  // Lines up with rd_data
    end
  end

  always_comb begin
    if (!f2.de) begin
      pix_rgb = '0;  // Blanking
    end else if (!f2.win) begin
      pix_rgb = BORDER_RGB;
    end else if (palette_sel) begin
      pix_rgb = PALETTE_GRAY[rd_data];
    end else begin
      pix_rgb = PALETTE_GREEN[rd_data];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      video <= '0;
    end else begin
      video.hs  <= f2.hs;  // Stage 3
      video.vs  <= f2.vs;
      video.de  <= f2.de;
      video.rgb <= pix_rgb;
    end
  end

  // Sync pulse never overlaps active video at the output
  a_de_hs: assert property (@(posedge clk) disable iff (rst)
    !(video.de && video.hs));

  // Window reads stay within the buffer
  a_rd_range: assert property (@(posedge clk) disable iff (rst)
    f1.win |-> rd_addr < fb_addr_t'(FB_DEPTH));

endmodule

// ==== rtl/frame_buffer.sv ====
`timescale 1ns/1ps

module frame_buffer import gb_lcd_pkg::*; (
  input  logic      clk,
  input  fb_write_t wr,       // Capture side
  input  fb_addr_t  rd_addr,  // Scanout side
  output shade_t    rd_data   // One cycle after rd_addr
);

  // One shade per LCD pixel, row-major
  shade_t mem [FB_DEPTH];

  // Single clock, so write and read share the block
  always_ff @(posedge clk) begin
    if (wr.en) begin
      mem[wr.addr] <= wr.data;
    end
  end

  // Read port always enabled
  // Same-address collision returns the old word
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

  //////////////////////////////////////////////////
  // Checks

  // Producer keeps its writes within depth
  a_wr_depth: assert property (@(posedge clk)
    wr.en |-> wr.addr < fb_addr_t'(FB_DEPTH));

endmodule

// ==== rtl/lcd_capture.sv ====
`timescale 1ns/1ps

module lcd_capture import gb_lcd_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  lcd_bus_t  lcd,   // From emulator core
  output fb_write_t wr     // To frame buffer
);

  //////////////////////////////////////////////////
  // Input register and edge detect

  lcd_bus_t lcd_q;  // Sampled bus
  lcd_bus_t lcd_d;  // Sample one cycle older
  logic     vs_rise;
  logic     hs_rise;
  logic     cpl_rise;

  always_ff @(posedge clk) begin
    if (rst) begin
      lcd_q <= '0;
      lcd_d <= '0;
    end else begin
      lcd_q <= lcd;
      lcd_d <= lcd_q;
    end
  end

  assign vs_rise  = lcd_q.vs & ~lcd_d.vs;
  assign hs_rise  = lcd_q.hs & ~lcd_d.hs;
  assign cpl_rise = lcd_q.cpl & ~lcd_d.cpl;

  //////////////////////////////////////////////////
  // Position tracking

  lcd_x_t   x;         // Next column to write
  lcd_y_t   y;         // Current row
  logic     in_range;
  fb_addr_t addr;

  assign in_range = (x < lcd_x_t'(LCD_W)) && (y < lcd_y_t'(LCD_H));
  assign addr     = fb_addr_t'(y) * fb_addr_t'(LCD_W) + fb_addr_t'(x);  // Row-major

  // vs beats hs, hs beats cpl
  always_ff @(posedge clk) begin
    if (rst || vs_rise) begin
      x <= '0;
      y <= '0;
    end else if (hs_rise) begin
      x <= '0;
      if (y != '1) begin
        y <= y + 1'b1;  // Saturate past the last row
      end
    end else if (cpl_rise && lcd_q.valid) begin
      if (x != '1) begin
        x <= x + 1'b1;  // Extra pulses pile up at the end
      end
    end
  end

  //////////////////////////////////////////////////
  // Write register with a one-cycle pulse

  always_ff @(posedge clk) begin
    wr.addr <= addr;
    wr.data <= lcd_q.pixel;
    if (rst) begin
      wr.en <= 1'b0;
    end else begin
      wr.en <= cpl_rise & lcd_q.valid & in_range & ~vs_rise & ~hs_rise;
    end
  end

  // Writes land inside the 160x144 buffer
  a_addr_range: assert property (@(posedge clk) disable iff (rst)
    wr.en |-> wr.addr < fb_addr_t'(FB_DEPTH));

  // Column behind each write was still inside the line
  a_col_range: assert property (@(posedge clk) disable iff (rst)
    wr.en |-> $past(x) < lcd_x_t'(LCD_W));

endmodule

// ==== rtl/dvi_pkg.sv ====
package dvi_pkg;

  // Horizontal timing in pixels
  localparam int H_ACTIVE = 360;
  localparam int H_FRONT  = 8;
  localparam int H_SYNC   = 16;
  localparam int H_BACK   = 16;
  localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;  // 400

  // Vertical timing in lines
  localparam int V_ACTIVE = 300;
  localparam int V_FRONT  = 2;
  localparam int V_SYNC   = 4;
  localparam int V_BACK   = 4;
  localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;  // 310

  typedef logic [8:0] hcount_t;
  typedef logic [8:0] vcount_t;
  typedef logic [7:0] color_t;

  typedef struct packed {
    color_t r;
    color_t g;
    color_t b;
  } rgb_t;

  typedef struct packed {
    logic hs;
    logic vs;
    logic de;   // Active video
    rgb_t rgb;
  } dvi_video_t;

  localparam rgb_t BORDER_RGB = '{r: 8'h20, g: 8'h20, b: 8'h40};  // Dark blue

  // Indexed by shade, lightest first
  localparam rgb_t PALETTE_GREEN [4] = '{
    '{r: 8'h9b, g: 8'hbc, b: 8'h0f},
    '{r: 8'h8b, g: 8'hac, b: 8'h0f},
    '{r: 8'h30, g: 8'h62, b: 8'h30},
    '{r: 8'h0f, g: 8'h38, b: 8'h0f}
  };

  localparam rgb_t PALETTE_GRAY [4] = '{
    '{r: 8'hff, g: 8'hff, b: 8'hff},
    '{r: 8'haa, g: 8'haa, b: 8'haa},
    '{r: 8'h55, g: 8'h55, b: 8'h55},
    '{r: 8'h00, g: 8'h00, b: 8'h00}
  };

endpackage

// ==== rtl/gb_lcd_pkg.sv ====
package gb_lcd_pkg;

  // LCD geometry
  localparam int LCD_W    = 160;
  localparam int LCD_H    = 144;
  localparam int FB_DEPTH = LCD_W * LCD_H;  // 23040 words

  typedef logic [1:0]  shade_t;    // 0 lightest, 3 darkest
  typedef logic [7:0]  lcd_x_t;    // Column
  typedef logic [7:0]  lcd_y_t;    // Row
  typedef logic [14:0] fb_addr_t;  // Row * 160 + column

  // Strobes and levels straight from the core
  typedef struct packed {
    logic   hs;     // Line end strobe
    logic   vs;     // Frame start strobe
    logic   cpl;    // Pixel latch
    logic   valid;  // Qualifies the latch
    shade_t pixel;
  } lcd_bus_t;

  // One buffer write
  typedef struct packed {
    logic     en;
    fb_addr_t addr;
    shade_t   data;
  } fb_write_t;

endpackage
